// ==== logic/relay_seq_pkg.sv ====
/*
 * shared definitions for the relay computer instruction sequencer
 * one-hot cycle state enum, instruction class, register and address source enums,
 * decoded instruction and control word structs, cycle length constants
 */
package relay_seq_pkg;

	// one bit per cycle state, bit k-1 set means the machine is in state_k
	typedef enum logic [23:0] {
		state_1  = 24'h000001,
		state_2  = 24'h000002,
		state_3  = 24'h000004,
		state_4  = 24'h000008,
		state_5  = 24'h000010,
		state_6  = 24'h000020,
		state_7  = 24'h000040,
		state_8  = 24'h000080,
		state_9  = 24'h000100,
		state_10 = 24'h000200,
		state_11 = 24'h000400,
		state_12 = 24'h000800,
		state_13 = 24'h001000,
		state_14 = 24'h002000,
		state_15 = 24'h004000,
		state_16 = 24'h008000,
		state_17 = 24'h010000,
		state_18 = 24'h020000,
		state_19 = 24'h040000,
		state_20 = 24'h080000,
		state_21 = 24'h100000,
		state_22 = 24'h200000,
		state_23 = 24'h400000,
		state_24 = 24'h800000
	} seq_state_t;

	// class codes are the same four bits the relay decode logic produces
	typedef enum logic [3:0] {
		mov_8                    = 4'b0000,
		alu                      = 4'b1000,
		setab                    = 4'b0100,
		inc_xy                   = 4'b1011,
		load_store               = 4'b1001,
		goto                     = 4'b1100,
		mov16_halt_return_branch = 4'b1010
	} instr_class_t;

	// register names in the order the opcode fields encode them
	typedef enum logic [2:0] {a, b, c, d, m1, m2, x, y} reg_t;

	// source that drives the address bus, encoded as the rr field of a load or store
	typedef enum logic [1:0] {pc, m, xy, j} addr_src_t;

	typedef struct packed {
		instr_class_t cls;
		reg_t         dst;
		reg_t         src;
		logic         sel;
		logic [2:0]   alu_fn;
		logic [4:0]   imm;
		addr_src_t    addr_src;
		logic         is_store;
		logic         is_halt;
	} decoded_t;

	// a field only carries a value in a cycle where its enable is set
	typedef struct packed {
		logic       src_en;
		reg_t       src;
		logic       load_en;
		reg_t       dst;
		logic       imm_en;
		logic [7:0] imm8;
		logic       alu_en;
		logic [2:0] alu_fn;
		logic       mem_read;
		logic       mem_write;
		logic       addr_en;
		addr_src_t  addr_src;
		logic       inc_en;
		logic       link_save;
		logic       pc_load;
		logic       halt;
	} ctrl_t;

	// number of clock periods each instruction class takes, state_1 included
	localparam logic [4:0] len_short = 5'd8;
	localparam logic [4:0] len_mid   = 5'd12;
	localparam logic [4:0] len_inc   = 5'd14;
	localparam logic [4:0] len_long  = 5'd24;

endpackage

// ==== logic/instr_decoder.sv ====
/*
 * opcode decoder for the relay sequencer
 * accepts an opcode byte on a valid/ready port, sorts it into an instruction class
 * and registers the operand fields
 */
`timescale 1ns/1ps

module instr_decoder (
	input  logic                  clock,
	input  logic                  rst_n,
	input  logic [7:0]            instr,
	input  logic                  instr_valid,
	input  logic                  instr_ready,
	output logic                  start,
	output relay_seq_pkg::decoded_t dec
);

	import relay_seq_pkg::*;

	decoded_t   nxt;
	logic [4:0] nxt_len;
	// edges left until the cycle machine should be back in state_1
	logic [4:0] remain;

	// a transfer happens on the edge where both sides agree
	assign start = instr_valid && instr_ready;

	// classify by the top bits, then pick the fields that class uses
	always_comb
	begin
		nxt = '0;
		case (instr[7:6])
			2'b00:
			begin
				nxt.cls = mov_8;
				nxt.dst = reg_t'(instr[5:3]);
				nxt.src = reg_t'(instr[2:0]);
			end
			2'b01:
			begin
				nxt.cls = setab;
				nxt.sel = instr[5];
				nxt.imm = instr[4:0];
				nxt.dst = instr[5] ? b : a;
			end
			2'b11:
			begin
				// the link bit rides on sel, the address always starts at pc
				nxt.cls      = goto;
				nxt.sel      = instr[5];
				nxt.addr_src = pc;
			end
			default:
			begin
				case (instr[5:4])
					2'b00:
					begin
						nxt.cls    = alu;
						nxt.sel    = instr[3];
						nxt.alu_fn = instr[2:0];
						nxt.dst    = instr[3] ? d : a;
					end
					2'b01:
					begin
						nxt.cls      = load_store;
						nxt.is_store = instr[3];
						nxt.addr_src = addr_src_t'(instr[1:0]);
						nxt.dst      = reg_t'({1'b0, instr[1:0]});
					end
					2'b10:
					begin
						// 16 bit move collapsed to a single strobe pair, bit 3 picks m1 or x
						nxt.cls     = mov16_halt_return_branch;
						nxt.src     = instr[3] ? x : m1;
						nxt.dst     = instr[3] ? x : m1;
						nxt.is_halt = (instr == 8'b1010_1110);
					end
					default:
					begin
						nxt.cls      = inc_xy;
						nxt.dst      = x;
						nxt.addr_src = xy;
					end
				endcase
			end
		endcase
	end

	// cycle length of the incoming class, used to watch the cycle machine
	always_comb
	begin
		case (nxt.cls)
			mov_8, alu, setab:                    nxt_len = len_short;
			load_store, mov16_halt_return_branch: nxt_len = len_mid;
			inc_xy:                               nxt_len = len_inc;
			default:                              nxt_len = len_long;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (start)
			dec <= nxt;
	end

	always_ff @(posedge clock)
	begin
		if (!rst_n)
			remain <= '0;
		else if (start)
			remain <= nxt_len - 5'd1;
		else if (remain != 5'd0)
			remain <= remain - 5'd1;
	end

	// the class registered on an accept must be one the cycle machine knows
	assert property (@(posedge clock) disable iff (!rst_n)
		start |=> dec.cls inside {mov_8, alu, setab, inc_xy, load_store, goto,
			mov16_halt_return_branch});

	// ready stays low for the whole instruction and comes back after exactly its length
	assert property (@(posedge clock) disable iff (!rst_n)
		(remain != 5'd0) |-> !instr_ready);
	assert property (@(posedge clock) disable iff (!rst_n)
		(remain == 5'd1) && !dec.is_halt |=> instr_ready);

endmodule

// ==== logic/cycle_fsm.sv ====
/*
 * one-hot cycle state machine of the relay sequencer
 * 24 states, wrap point chosen from the instruction class, halted flag and ready
 */
`timescale 1ns/1ps

module cycle_fsm (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic                        start,
	input  relay_seq_pkg::instr_class_t cls,
	input  logic                        is_halt,
	output relay_seq_pkg::seq_state_t   state,
	output logic                        instr_ready
);

	import relay_seq_pkg::*;

	seq_state_t next_state;
	logic       halted;

	always_ff @(posedge clock)
	begin
		if (!rst_n)
			state <= state_1;
		else
			state <= next_state;
	end

	// a halt instruction freezes the machine once its last cycle has run
	always_ff @(posedge clock)
	begin
		if (!rst_n)
			halted <= 1'b0;
		else if ((state == state_12) && is_halt)
			halted <= 1'b1;
	end

	// pure Moore machine, ready only looks at the registered state and flag
	assign instr_ready = (state == state_1) && !halted;

	// each state steps to the next, the class only matters at 8, 12 and 14
	always_comb
	begin
		unique case (state)
			state_1:  next_state = start ? state_2 : state_1;
			state_2:  next_state = state_3;
			state_3:  next_state = state_4;
			state_4:  next_state = state_5;
			state_5:  next_state = state_6;
			state_6:  next_state = state_7;
			state_7:  next_state = state_8;
			state_8:
			begin
				if (cls inside {mov_8, alu, setab})
					next_state = state_1;
				else
					next_state = state_9;
			end
			state_9:  next_state = state_10;
			state_10: next_state = state_11;
			state_11: next_state = state_12;
			state_12:
			begin
				if (cls inside {load_store, mov16_halt_return_branch})
					next_state = state_1;
				else
					next_state = state_13;
			end
			state_13: next_state = state_14;
			state_14:
			begin
				// only goto is left once inc_xy has wrapped
				if (cls == inc_xy)
					next_state = state_1;
				else
					next_state = state_15;
			end
			state_15: next_state = state_16;
			state_16: next_state = state_17;
			state_17: next_state = state_18;
			state_18: next_state = state_19;
			state_19: next_state = state_20;
			state_20: next_state = state_21;
			state_21: next_state = state_22;
			state_22: next_state = state_23;
			state_23: next_state = state_24;
			state_24: next_state = state_1;
			default:  next_state = state_1;
		endcase
	end

	// exactly one relay of the state chain is energised at any time
	assert property (@(posedge clock) disable iff (!rst_n) $onehot(state));

	// the machine rests in state_1 until the decoder reports an accepted opcode
	assert property (@(posedge clock) disable iff (!rst_n)
		(state == state_1) && !start |=> (state == state_1));

endmodule

// ==== logic/control_pulse_gen.sv ====
/*
 * control pulse generator of the relay sequencer
 * combinational table from the active state and decoded instruction to the control word
 */
`timescale 1ns/1ps

module control_pulse_gen (
	input  logic                      clock,
	input  logic                      rst_n,
	input  relay_seq_pkg::seq_state_t state,
	input  relay_seq_pkg::decoded_t   dec,
	output relay_seq_pkg::ctrl_t      ctrl
);

	import relay_seq_pkg::*;

	// state bits renumbered so that st_on[k] is state_k
	logic [24:1] st_on;

	assign st_on = state;

	always_comb
	begin
		// everything stays low unless a rule below fires for this state
		ctrl = '0;
		case (dec.cls)
			mov_8:
			begin
				if (st_on[5] || st_on[6])
				begin
					ctrl.src_en = 1'b1;
					ctrl.src    = dec.src;
				end
				if (st_on[6])
				begin
					ctrl.load_en = 1'b1;
					ctrl.dst     = dec.dst;
				end
			end
			setab:
			begin
				// five bit immediate is sign extended onto the data bus
				if (st_on[5] || st_on[6])
				begin
					ctrl.imm_en = 1'b1;
					ctrl.imm8   = {{3{dec.imm[4]}}, dec.imm};
				end
				if (st_on[6])
				begin
					ctrl.load_en = 1'b1;
					ctrl.dst     = dec.dst;
				end
			end
			alu:
			begin
				if (st_on[5] || st_on[6])
				begin
					ctrl.alu_en = 1'b1;
					ctrl.alu_fn = dec.alu_fn;
				end
				if (st_on[6])
				begin
					ctrl.load_en = 1'b1;
					ctrl.dst     = dec.dst;
				end
			end
			load_store:
			begin
				if (|st_on[11:9])
				begin
					ctrl.addr_en  = 1'b1;
					ctrl.addr_src = dec.addr_src;
				end
				if (st_on[10] || st_on[11])
				begin
					ctrl.mem_write = dec.is_store;
					ctrl.mem_read  = !dec.is_store;
				end
				// a load latches the data bus into the register picked by rr
				if (st_on[11] && !dec.is_store)
				begin
					ctrl.load_en = 1'b1;
					ctrl.dst     = dec.dst;
				end
			end
			mov16_halt_return_branch:
			begin
				if (dec.is_halt)
					ctrl.halt = st_on[12];
				else if (st_on[11])
				begin
					ctrl.src_en  = 1'b1;
					ctrl.src     = dec.src;
					ctrl.load_en = 1'b1;
					ctrl.dst     = dec.dst;
				end
			end
			inc_xy:
			begin
				// xy sits on the address bus while the incrementer settles
				if (|st_on[13:9])
				begin
					ctrl.addr_en  = 1'b1;
					ctrl.addr_src = dec.addr_src;
				end
				ctrl.inc_en = st_on[13];
				if (st_on[14])
				begin
					ctrl.load_en = 1'b1;
					ctrl.dst     = dec.dst;
				end
			end
			goto:
			begin
				// two operand bytes are fetched through pc, then the jump is taken
				if (|st_on[22:15])
				begin
					ctrl.addr_en  = 1'b1;
					ctrl.addr_src = dec.addr_src;
				end
				ctrl.mem_read  = st_on[17] || st_on[18] || st_on[21] || st_on[22];
				ctrl.link_save = st_on[23] && dec.sel;
				ctrl.pc_load   = st_on[24];
			end
			default:
			begin
				ctrl = '0;
			end
		endcase
	end

	// the memory relays must never be asked to read and write together
	assert property (@(posedge clock) disable iff (!rst_n)
		!(ctrl.mem_read && ctrl.mem_write));

	// no register is loaded while the machine is idle
	assert property (@(posedge clock) disable iff (!rst_n)
		(state == state_1) |-> !ctrl.load_en);

endmodule

// ==== logic/relay_sequencer.sv ====
/*
 * top level of the relay computer instruction sequencer
 * joins opcode decoder, cycle state machine and control pulse generator
 */
`timescale 1ns/1ps

module relay_sequencer (
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic [7:0]                instr,
	input  logic                      instr_valid,
	output logic                      instr_ready,
	output relay_seq_pkg::ctrl_t      ctrl,
	output relay_seq_pkg::seq_state_t state
);

	import relay_seq_pkg::*;

	// one cycle accept strobe from the decoder into the cycle machine
	logic     start;
	// decoded fields, held for the whole instruction
	decoded_t dec;

	instr_decoder u_decoder (
		.clock       (clock),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.start       (start),
		.dec         (dec)
	);

	// the class and halt bit decide where the state chain wraps
	cycle_fsm u_cycle_fsm (
		.clock       (clock),
		.rst_n       (rst_n),
		.start       (start),
		.cls         (dec.cls),
		.is_halt     (dec.is_halt),
		.state       (state),
		.instr_ready (instr_ready)
	);

	control_pulse_gen u_pulse_gen (
		.clock (clock),
		.rst_n (rst_n),
		.state (state),
		.dec   (dec),
		.ctrl  (ctrl)
	);

endmodule

// ==== test/seq_ref_model.svh ====
/*
 * reference model of the relay sequencer for the testbench
 * instruction class from the opcode bits, cycle length per class,
 * expected control word for an opcode in a given state number
 */
`ifndef SEQ_REF_MODEL_SVH
`define SEQ_REF_MODEL_SVH

// the top two bits pick most classes, the 10 group is split by bits 5 and 4
function automatic instr_class_t class_of(input logic [7:0] op);
	casez (op)
		8'b00??_????: return mov_8;
		8'b01??_????: return setab;
		8'b11??_????: return goto;
		8'b1000_????: return alu;
		8'b1001_????: return load_store;
		8'b1010_????: return mov16_halt_return_branch;
		default:      return inc_xy;
	endcase
endfunction

// clock periods the instruction takes, counting the idle state_1 cycle
function automatic int length_of(input logic [7:0] op);
	case (class_of(op))
		mov_8, alu, setab:                    return int'(len_short);
		load_store, mov16_halt_return_branch: return int'(len_mid);
		inc_xy:                               return int'(len_inc);
		default:                              return int'(len_long);
	endcase
endfunction

// control word expected while state_k is active and op is the current opcode
function automatic ctrl_t expected_ctrl(input logic [7:0] op, input int k);
	ctrl_t             c;
	logic signed [7:0] imm_wide;
	c = '0;
	imm_wide = $signed(op[4:0]);
	case (class_of(op))
		mov_8:
		begin
			c.src_en  = (k == 5) || (k == 6);
			c.src     = c.src_en ? reg_t'(op[2:0]) : a;
			c.load_en = (k == 6);
			c.dst     = c.load_en ? reg_t'(op[5:3]) : a;
		end
		setab:
		begin
			c.imm_en  = (k == 5) || (k == 6);
			c.imm8    = c.imm_en ? imm_wide : 8'h00;
			c.load_en = (k == 6);
			if (c.load_en)
				c.dst = op[5] ? b : a;
		end
		alu:
		begin
			c.alu_en  = (k == 5) || (k == 6);
			c.alu_fn  = c.alu_en ? op[2:0] : 3'b000;
			c.load_en = (k == 6);
			if (c.load_en)
				c.dst = op[3] ? d : a;
		end
		load_store:
		begin
			c.addr_en  = k inside {[9:11]};
			c.addr_src = c.addr_en ? addr_src_t'(op[1:0]) : pc;
			// bit 3 set means a store
			c.mem_write = op[3] && (k inside {[10:11]});
			c.mem_read  = !op[3] && (k inside {[10:11]});
			c.load_en   = !op[3] && (k == 11);
			c.dst       = c.load_en ? reg_t'({1'b0, op[1:0]}) : a;
		end
		mov16_halt_return_branch:
		begin
			if (op == 8'hae)
				c.halt = (k == 12);
			else if (k == 11)
			begin
				c.src_en  = 1'b1;
				c.src     = op[3] ? x : m1;
				c.load_en = 1'b1;
				c.dst     = op[3] ? x : m1;
			end
		end
		inc_xy:
		begin
			c.addr_en  = k inside {[9:13]};
			c.addr_src = c.addr_en ? xy : pc;
			c.inc_en   = (k == 13);
			c.load_en  = (k == 14);
			c.dst      = c.load_en ? x : a;
		end
		default:
		begin
			// goto reads two address bytes through pc before loading it
			c.addr_en   = k inside {[15:22]};
			c.addr_src  = pc;
			c.mem_read  = k inside {17, 18, 21, 22};
			c.link_save = (k == 23) && op[5];
			c.pc_load   = (k == 24);
		end
	endcase
	return c;
endfunction

`endif

// ==== test/tb_relay_sequencer.sv ====
/*
 * testbench for the relay computer instruction sequencer
 * clock and reset, directed and random opcode stimulus, a compare process against
 * the reference model, a watchdog and per-test reporting
 */
`timescale 1ns/1ps

module tb_relay_sequencer;

	import relay_seq_pkg::*;

	`include "seq_ref_model.svh"

	// one opcode per class for the cycle length test, the rest come from the random run
	localparam int op_count    = 7 + 200 + 3;
	localparam int watchdog_ns = (op_count + 10) * 30 * 10;

	logic       clock;
	logic       rst_n;
	logic [7:0] instr;
	logic       instr_valid;
	logic       instr_ready;
	ctrl_t      ctrl;
	seq_state_t state;

	// model of the sequencer as seen from outside
	int         exp_num;
	logic [7:0] cur_op;
	logic       model_halted;
	ctrl_t      want_ctrl;
	logic       want_ready;

	int         errors;
	int         test_base;
	int         tests_run;
	int         tests_failed;
	string      test_name;
	logic [7:0] class_ops [7] = '{8'h0a, 8'h8b, 8'h7f, 8'hb0, 8'h92, 8'ha9, 8'he5};

	relay_sequencer DUT (
		.clock       (clock),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.instr_ready (instr_ready),
		.ctrl        (ctrl),
		.state       (state)
	);

	always #5 clock = ~clock;

	function automatic seq_state_t state_for(input int k);
		return seq_state_t'(24'h1 << (k - 1));
	endfunction

	task automatic report_value(input string what, input logic [31:0] want,
		input logic [31:0] got);
		$display("FAILED %s: %s expected %h actual %h", test_name, what, want, got);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("%s: %s", test_name, what);
		errors++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_base = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors == test_base)
			$display("test %-14s ok", test_name);
		else
		begin
			tests_failed++;
			$display("test %-14s %0d errors", test_name, errors - test_base);
		end
	endtask

	// reset low for two clock periods, released on a falling edge
	task automatic reset_dut();
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		repeat (2) @(negedge clock);
		rst_n = 1'b1;
	endtask

	task automatic check_idle();
		if (state !== state_1)
			report_value("state", state_1, state);
		if (ctrl !== ctrl_t'(0))
			report_value("ctrl", 32'h0, ctrl);
		if (instr_ready !== 1'b1)
			report_value("instr_ready", 32'h1, instr_ready);
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!instr_ready && n < 40)
		begin
			@(negedge clock);
			n++;
		end
		if (!instr_ready)
			report_problem("instr_ready did not come back within 40 cycles");
	endtask

	// offer one opcode for a single cycle, ready must already be high
	task automatic send_op(input logic [7:0] op);
		instr       = op;
		instr_valid = 1'b1;
		@(posedge clock);
		@(negedge clock);
		instr_valid = 1'b0;
	endtask

	// edges since the accepting edge until ready is seen high again
	task automatic count_busy(output int n);
		n = 0;
		while (!instr_ready && n < 40)
		begin
			@(negedge clock);
			n++;
		end
	endtask

	// compares the outputs settled from the last edge, then steps the model
	always @(posedge clock)
	begin
		if (!rst_n)
		begin
			exp_num      = 1;
			cur_op       = 8'h00;
			model_halted = 1'b0;
		end
		else
		begin
			want_ctrl  = expected_ctrl(cur_op, exp_num);
			want_ready = (exp_num == 1) && !model_halted;
			if (!$onehot(state))
				report_problem($sformatf("state %h is not one-hot", state));
			if (state !== state_for(exp_num))
				report_value("state", state_for(exp_num), state);
			if (ctrl !== want_ctrl)
				report_value($sformatf("ctrl of op %h in state_%0d", cur_op, exp_num),
					want_ctrl, ctrl);
			if (instr_ready !== want_ready)
				report_value("instr_ready", want_ready, instr_ready);
			if (want_ready && instr_valid)
			begin
				cur_op  = instr;
				exp_num = 2;
			end
			else if (exp_num != 1 && exp_num == length_of(cur_op))
			begin
				// the halt opcode freezes the machine on its last edge
				if (cur_op == 8'hae)
					model_halted = 1'b1;
				exp_num = 1;
			end
			else if (exp_num != 1)
				exp_num++;
		end
	end

	initial
	begin : stimulus
		int         cycles;
		logic [7:0] op;
		logic       saw_halt;
		clock        = 1'b0;
		rst_n        = 1'b0;
		instr        = 8'h00;
		instr_valid  = 1'b0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		void'($urandom(79));

		start_test("after_reset");
		reset_dut();
		check_idle();
		end_test();

		start_test("cycle_length");
		foreach (class_ops[i])
		begin
			wait_ready();
			send_op(class_ops[i]);
			count_busy(cycles);
			if (cycles != length_of(class_ops[i]) - 1)
				report_value($sformatf("busy cycles of op %h", class_ops[i]),
					length_of(class_ops[i]) - 1, cycles);
		end
		end_test();

		start_test("control_word");
		repeat (200)
		begin
			op = $urandom;
			while (op == 8'hae)
				op = $urandom;
			// idle gap with junk on the opcode lines
			repeat ($urandom_range(3))
			begin
				instr = $urandom;
				@(negedge clock);
			end
			wait_ready();
			send_op(op);
			count_busy(cycles);
			if (cycles != length_of(op) - 1)
				report_value($sformatf("busy cycles of op %h", op), length_of(op) - 1, cycles);
		end
		end_test();

		start_test("back_pressure");
		wait_ready();
		instr       = 8'hc0;
		instr_valid = 1'b1;
		@(posedge clock);
		@(negedge clock);
		// the next opcode waits on the port while the goto runs
		instr = 8'h3a;
		count_busy(cycles);
		if (cycles != length_of(8'hc0) - 1)
			report_value("cycles held before accept", length_of(8'hc0) - 1, cycles);
		@(posedge clock);
		@(negedge clock);
		instr_valid = 1'b0;
		if (state !== state_2)
			report_value("state after accept", state_2, state);
		wait_ready();
		repeat (12)
		begin
			instr = $urandom;
			@(negedge clock);
			check_idle();
		end
		end_test();

		start_test("halt");
		wait_ready();
		send_op(8'hae);
		saw_halt = 1'b0;
		repeat (15)
		begin
			@(negedge clock);
			if (ctrl.halt && state === state_12)
				saw_halt = 1'b1;
			else if (ctrl.halt)
				report_value("state with halt set", state_12, state);
		end
		if (!saw_halt)
			report_problem("ctrl.halt was never set in state_12");
		// the offered opcode stays put while the port is not ready
		instr_valid = 1'b1;
		instr       = $urandom;
		repeat (50)
		begin
			@(negedge clock);
			if (instr_ready)
				report_problem("instr_ready rose after the halt");
		end
		instr_valid = 1'b0;
		reset_dut();
		check_idle();
		end_test();

		$display("%0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
			tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	initial
	begin
		#(watchdog_ns * 1ns);
		$display("timeout: the run did not finish within %0d ns", watchdog_ns);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== relay_seq.f ====
+incdir+test
logic/relay_seq_pkg.sv
logic/instr_decoder.sv
logic/cycle_fsm.sv
logic/control_pulse_gen.sv
logic/relay_sequencer.sv
test/tb_relay_sequencer.sv

// ==== Bender.yml ====
package:
  name: relay_seq

sources:
  # shared package first, then the blocks below the top level
  - logic/relay_seq_pkg.sv
  - logic/instr_decoder.sv
  - logic/cycle_fsm.sv
  - logic/control_pulse_gen.sv
  - logic/relay_sequencer.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_relay_sequencer.sv
